// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = kcpu_ctrl_tb
FILELIST  = kcpu_ctrl.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: kcpu_ctrl.f
source/kcpu_isa_pkg.sv
source/kcpu_ucode_pkg.sv
source/kcpu_opcat_decoder.sv
source/kcpu_idx_decoder.sv
source/kcpu_ucode_rom.sv
source/kcpu_ucode_seq.sv
source/kcpu_ctrl.sv
tests/tb_clock.sv
tests/kcpu_ctrl_tb.sv

// File: source/kcpu_ctrl.sv
// Control unit top joining the opcode and postbyte decoders to the microcode sequencer
`timescale 1ns/1ps
`default_nettype none

module kcpu_ctrl import kcpu_isa_pkg::*, kcpu_ucode_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic [7:0]         op,
    input  logic [7:0]         mdata,
    input  logic               mem_busy,
    input  logic               nmi_n,
    input  logic               firq_n,
    input  logic               irq_n,
    output logic [ctl_w-1:0]   ctl,
    output logic [2:0]         idx_rsel_q,
    output logic [1:0]         idx_asel_q,
    output logic [3:0]         intvec,
    output logic [uaddr_w-1:0] upc,
    output logic               buserror
);

    logic [opcat_aw-1:0] opcat;
    logic [opcat_aw-1:0] nx_cat;
    logic [opcat_aw-1:0] idx_cat;
    logic [2:0]          idx_rsel;
    logic [1:0]          idx_asel;
    logic                idx_ind_rq;

    kcpu_opcat_decoder u_opcat (
        .op     (op),
        .opcat  (opcat),
        .nx_cat (nx_cat)
    );

    kcpu_idx_decoder u_idx (
        .mdata      (mdata),
        .idx_cat    (idx_cat),
        .idx_rsel   (idx_rsel),
        .idx_asel   (idx_asel),
        .idx_ind_rq (idx_ind_rq)
    );

    kcpu_ucode_seq u_seq (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .mem_busy   (mem_busy),
        .nmi_n      (nmi_n),
        .firq_n     (firq_n),
        .irq_n      (irq_n),
        .opcat      (opcat),
        .nx_cat     (nx_cat),
        .idx_cat    (idx_cat),
        .idx_rsel   (idx_rsel),
        .idx_asel   (idx_asel),
        .idx_ind_rq (idx_ind_rq),
        .ctl        (ctl),
        .idx_rsel_q (idx_rsel_q),
        .idx_asel_q (idx_asel_q),
        .intvec     (intvec),
        .upc        (upc),
        .buserror   (buserror)
    );

endmodule

`default_nettype wire

// File: source/kcpu_idx_decoder.sv
// Indexed postbyte decoder giving the addressing mode routine and register selects
`timescale 1ns/1ps
`default_nettype none

module kcpu_idx_decoder import kcpu_isa_pkg::*; (
    input  logic [7:0]          mdata,
    output logic [opcat_aw-1:0] idx_cat,
    output logic [2:0]          idx_rsel,
    output logic [1:0]          idx_asel,
    output logic                idx_ind_rq
);

    always_comb begin
        case ({mdata[7], mdata[2:0]})
            pb_rinc:  idx_cat = cat_idx_rinc;
            pb_rinc2: idx_cat = cat_idx_rinc2;
            pb_rdec:  idx_cat = cat_idx_rdec;
            pb_rdec2: idx_cat = cat_idx_rdec2;
            pb_off8:  idx_cat = cat_idx_off8;
            pb_off16: idx_cat = cat_idx_off16;
            pb_r:     idx_cat = cat_idx_r;
            pb_ext:   idx_cat = cat_idx_ext;
            pb_dp:    idx_cat = cat_idx_dp;
            pb_acc_a,
            pb_acc_b,
            pb_acc_d: idx_cat = cat_idx_acc;
            default:  idx_cat = cat_buserror;
        endcase
    end

    assign idx_rsel   = mdata[6:4];  // base register
    assign idx_asel   = mdata[1:0];  // accumulator offset
    assign idx_ind_rq = mdata[3];

endmodule

`default_nettype wire

// File: source/kcpu_isa_pkg.sv
// Instruction set constants for the kcpu control unit with opcodes, routine categories and postbyte modes
`default_nettype none

package kcpu_isa_pkg;

    localparam int opcat_aw = 6;    // routine category width

    // trimmed opcode map
    localparam logic [7:0] lda_imm  = 8'h86;
    localparam logic [7:0] ldb_imm  = 8'hc6;
    localparam logic [7:0] adda_imm = 8'h8b;
    localparam logic [7:0] suba_imm = 8'h80;
    localparam logic [7:0] cmpa_imm = 8'h81;
    localparam logic [7:0] ldd_imm  = 8'hcc;
    localparam logic [7:0] ldx_imm  = 8'h8e;
    localparam logic [7:0] cmpd_imm = 8'h83;
    localparam logic [7:0] clra     = 8'h4f;
    localparam logic [7:0] inca     = 8'h4c;
    localparam logic [7:0] deca     = 8'h4a;
    localparam logic [7:0] clrb     = 8'h5f;
    localparam logic [7:0] incb     = 8'h5c;
    localparam logic [7:0] decb     = 8'h5a;
    localparam logic [7:0] lda_idx  = 8'ha6;
    localparam logic [7:0] cmpa_idx = 8'ha1;
    localparam logic [7:0] ldd_idx  = 8'hec;
    localparam logic [7:0] sta      = 8'ha7;
    localparam logic [7:0] stb      = 8'he7;
    localparam logic [7:0] std      = 8'hed;
    localparam logic [7:0] bra      = 8'h20;
    localparam logic [7:0] bne      = 8'h26;
    localparam logic [7:0] beq      = 8'h27;
    localparam logic [7:0] lbra     = 8'h16;
    localparam logic [7:0] jmp      = 8'h6e;
    localparam logic [7:0] jsr      = 8'had;
    localparam logic [7:0] rts      = 8'h39;
    localparam logic [7:0] rti      = 8'h3b;
    localparam logic [7:0] pushs    = 8'h34;
    localparam logic [7:0] puls     = 8'h35;
    localparam logic [7:0] mul      = 8'h3d;
    localparam logic [7:0] nop      = 8'h12;

    // instruction and service routines
    localparam logic [opcat_aw-1:0] cat_reset        = 6'd0;
    localparam logic [opcat_aw-1:0] cat_nmi          = 6'd1;
    localparam logic [opcat_aw-1:0] cat_firq         = 6'd2;
    localparam logic [opcat_aw-1:0] cat_irq          = 6'd3;
    localparam logic [opcat_aw-1:0] cat_single_alu   = 6'd4;
    localparam logic [opcat_aw-1:0] cat_single_alu16 = 6'd5;
    localparam logic [opcat_aw-1:0] cat_inh_a        = 6'd6;
    localparam logic [opcat_aw-1:0] cat_inh_b        = 6'd7;
    localparam logic [opcat_aw-1:0] cat_cmp8         = 6'd8;
    localparam logic [opcat_aw-1:0] cat_cmp16        = 6'd9;
    localparam logic [opcat_aw-1:0] cat_alu_idx      = 6'd10;
    localparam logic [opcat_aw-1:0] cat_alu_idx16    = 6'd11;
    localparam logic [opcat_aw-1:0] cat_store8       = 6'd12;
    localparam logic [opcat_aw-1:0] cat_store16      = 6'd13;
    localparam logic [opcat_aw-1:0] cat_sbranch      = 6'd14;
    localparam logic [opcat_aw-1:0] cat_lbranch      = 6'd15;
    localparam logic [opcat_aw-1:0] cat_jump         = 6'd16;
    localparam logic [opcat_aw-1:0] cat_jsr          = 6'd17;
    localparam logic [opcat_aw-1:0] cat_rts          = 6'd18;
    localparam logic [opcat_aw-1:0] cat_rti          = 6'd19;
    localparam logic [opcat_aw-1:0] cat_psh          = 6'd20;
    localparam logic [opcat_aw-1:0] cat_pul          = 6'd21;
    localparam logic [opcat_aw-1:0] cat_mul          = 6'd22;
    localparam logic [opcat_aw-1:0] cat_nop          = 6'd23;
    localparam logic [opcat_aw-1:0] cat_parse_idx    = 6'd24;
    localparam logic [opcat_aw-1:0] cat_buserror     = 6'd25;

    // address formation routines for indexed modes
    localparam logic [opcat_aw-1:0] cat_idx_rinc     = 6'd32;
    localparam logic [opcat_aw-1:0] cat_idx_rinc2    = 6'd33;
    localparam logic [opcat_aw-1:0] cat_idx_rdec     = 6'd34;
    localparam logic [opcat_aw-1:0] cat_idx_rdec2    = 6'd35;
    localparam logic [opcat_aw-1:0] cat_idx_off8     = 6'd36;
    localparam logic [opcat_aw-1:0] cat_idx_off16    = 6'd37;
    localparam logic [opcat_aw-1:0] cat_idx_r        = 6'd38;
    localparam logic [opcat_aw-1:0] cat_idx_ext      = 6'd39;
    localparam logic [opcat_aw-1:0] cat_idx_acc      = 6'd40;
    localparam logic [opcat_aw-1:0] cat_idx_dp       = 6'd41;
    localparam logic [opcat_aw-1:0] cat_idx_ind      = 6'd42;

    // postbyte modes as {bit 7, bits 2..0}
    localparam logic [3:0] pb_rinc  = 4'b0_000;
    localparam logic [3:0] pb_rinc2 = 4'b0_001;
    localparam logic [3:0] pb_rdec  = 4'b0_010;
    localparam logic [3:0] pb_rdec2 = 4'b0_011;
    localparam logic [3:0] pb_off8  = 4'b0_100;
    localparam logic [3:0] pb_off16 = 4'b0_101;
    localparam logic [3:0] pb_r     = 4'b0_110;
    localparam logic [3:0] pb_ext   = 4'b0_111;
    localparam logic [3:0] pb_acc_a = 4'b1_000;
    localparam logic [3:0] pb_acc_b = 4'b1_001;
    localparam logic [3:0] pb_dp    = 4'b1_100;
    localparam logic [3:0] pb_acc_d = 4'b1_111;

endpackage

`default_nettype wire

// File: source/kcpu_opcat_decoder.sv
// Opcode category decoder mapping each fetched opcode to its microcode routine
`timescale 1ns/1ps
`default_nettype none

module kcpu_opcat_decoder import kcpu_isa_pkg::*; (
    input  logic [7:0]          op,
    output logic [opcat_aw-1:0] opcat,
    output logic [opcat_aw-1:0] nx_cat
);

    logic is_idx;  // opcode needs the postbyte parsed first

    always_comb begin
        is_idx = 1'b0;
        case (op)
            lda_imm, ldb_imm,
            adda_imm, suba_imm: nx_cat = cat_single_alu;
            ldd_imm, ldx_imm:   nx_cat = cat_single_alu16;
            clra, inca, deca:   nx_cat = cat_inh_a;
            clrb, incb, decb:   nx_cat = cat_inh_b;
            cmpa_imm:           nx_cat = cat_cmp8;
            cmpd_imm:           nx_cat = cat_cmp16;

            // operand through indexed address
            lda_idx: begin
                is_idx = 1'b1;
                nx_cat = cat_alu_idx;
            end
            cmpa_idx: begin
                is_idx = 1'b1;
                nx_cat = cat_cmp8;
            end
            ldd_idx: begin
                is_idx = 1'b1;
                nx_cat = cat_alu_idx16;
            end
            sta, stb: begin
                is_idx = 1'b1;
                nx_cat = cat_store8;
            end
            std: begin
                is_idx = 1'b1;
                nx_cat = cat_store16;
            end

            bra, beq, bne:      nx_cat = cat_sbranch;
            lbra:               nx_cat = cat_lbranch;
            jmp:                nx_cat = cat_jump;
            jsr:                nx_cat = cat_jsr;
            rts:                nx_cat = cat_rts;
            rti:                nx_cat = cat_rti;
            pushs:              nx_cat = cat_psh;
            puls:               nx_cat = cat_pul;
            mul:                nx_cat = cat_mul;
            nop:                nx_cat = cat_nop;
            default:            nx_cat = cat_buserror;  // undefined opcode
        endcase
    end

    assign opcat = is_idx ? cat_parse_idx : nx_cat;

endmodule

`default_nettype wire

// File: source/kcpu_ucode_pkg.sv
// Microcode word layout for the kcpu sequencer with flag masks and routine entry points
`default_nettype none

package kcpu_ucode_pkg;
    import kcpu_isa_pkg::*;

    localparam int step_w  = 2;
    localparam int uaddr_w = opcat_aw + step_w;  // category then step
    localparam int ucode_w = 16;
    localparam int ctl_w   = 12;

    // fmt = 0 selects the control view
    typedef struct packed {
        logic       fmt;
        logic [2:0] spare;
        logic       opd;
        logic       up_lda;
        logic       up_ldb;
        logic       up_ld16;
        logic       memhi;
        logic       we;
        logic       set_pc_branch8;
        logic       set_pc_branch16;
        logic       set_pc_jmp;
        logic       psh_go;
        logic       pul_go;
        logic       up_cc;
    } uctl_t;

    typedef struct packed {
        logic                fmt;
        logic                ni;
        logic                idx_jmp;
        logic                idx_ret;
        logic                halt;
        logic                int_en;
        logic [3:0]          spare;
        logic [opcat_aw-1:0] target;  // plain goto when no action bit set
    } useq_t;

    typedef union packed {
        uctl_t c;
        useq_t s;
    } uword_t;

    // control flag masks in uctl_t order
    localparam logic [ctl_w-1:0] f_opd     = 12'h800;
    localparam logic [ctl_w-1:0] f_up_lda  = 12'h400;
    localparam logic [ctl_w-1:0] f_up_ldb  = 12'h200;
    localparam logic [ctl_w-1:0] f_up_ld16 = 12'h100;
    localparam logic [ctl_w-1:0] f_memhi   = 12'h080;
    localparam logic [ctl_w-1:0] f_we      = 12'h040;
    localparam logic [ctl_w-1:0] f_br8     = 12'h020;
    localparam logic [ctl_w-1:0] f_br16    = 12'h010;
    localparam logic [ctl_w-1:0] f_jmp     = 12'h008;
    localparam logic [ctl_w-1:0] f_psh_go  = 12'h004;
    localparam logic [ctl_w-1:0] f_pul_go  = 12'h002;
    localparam logic [ctl_w-1:0] f_up_cc   = 12'h001;

    localparam logic [uaddr_w-1:0] reset_entry = {cat_reset, 2'd0};
    localparam logic [uaddr_w-1:0] nmi_entry   = {cat_nmi, 2'd0};
    localparam logic [uaddr_w-1:0] firq_entry  = {cat_firq, 2'd0};
    localparam logic [uaddr_w-1:0] irq_entry   = {cat_irq, 2'd0};

    localparam logic [3:0] iv_reset = 4'b1000;
    localparam logic [3:0] iv_nmi   = 4'b0100;
    localparam logic [3:0] iv_firq  = 4'b0010;
    localparam logic [3:0] iv_irq   = 4'b0001;
    localparam logic [3:0] iv_none  = 4'b0000;

endpackage

`default_nettype wire

// File: source/kcpu_ucode_rom.sv
// Microcode store holding one short routine per category as a constant table
`timescale 1ns/1ps
`default_nettype none

module kcpu_ucode_rom import kcpu_isa_pkg::*, kcpu_ucode_pkg::*; (
    input  logic [uaddr_w-1:0] addr,
    output uword_t             uword
);

    // routine shapes
    localparam logic [1:0] k_plain = 2'd0;
    localparam logic [1:0] k_int   = 2'd1;
    localparam logic [1:0] k_idx   = 2'd2;
    localparam logic [1:0] k_halt  = 2'd3;

    // action bits {ni, idx_jmp, idx_ret, halt, int_en}
    localparam logic [4:0] a_ni      = 5'b10000;
    localparam logic [4:0] a_idx_jmp = 5'b01000;
    localparam logic [4:0] a_idx_ret = 5'b00100;
    localparam logic [4:0] a_halt    = 5'b00010;
    localparam logic [4:0] a_int_en  = 5'b00001;

    logic [opcat_aw-1:0] cat;
    logic [step_w-1:0]   step;
    logic [ctl_w-1:0]    flags;
    logic [1:0]          kind;

    function automatic uword_t ctl_word(input logic [ctl_w-1:0] f);
        uword_t w;
        w = '0;
        w[ctl_w-1:0] = f;
        return w;
    endfunction

    function automatic uword_t seq_word(input logic [4:0] act, input logic [opcat_aw-1:0] tgt);
        uword_t w;
        w = '0;
        w.s.fmt = 1'b1;
        {w.s.ni, w.s.idx_jmp, w.s.idx_ret, w.s.halt, w.s.int_en} = act;
        w.s.target = tgt;
        return w;
    endfunction

    assign cat  = addr[uaddr_w-1:step_w];
    assign step = addr[step_w-1:0];

    always_comb begin
        flags = '0;
        kind  = k_plain;
        case (cat)
            cat_reset, cat_nop: flags = '0;
            cat_single_alu:     flags = f_opd | f_up_lda | f_up_cc;
            cat_single_alu16:   flags = f_opd | f_up_ld16 | f_memhi | f_up_cc;
            cat_inh_a:          flags = f_up_lda | f_up_cc;
            cat_inh_b:          flags = f_up_ldb | f_up_cc;
            cat_cmp8:           flags = f_opd | f_up_cc;
            cat_cmp16:          flags = f_opd | f_memhi | f_up_cc;
            cat_alu_idx:        flags = f_up_lda | f_up_cc;
            cat_alu_idx16:      flags = f_up_ld16 | f_memhi | f_up_cc;
            cat_store8:         flags = f_we;
            cat_store16:        flags = f_we | f_memhi;
            cat_sbranch:        flags = f_opd | f_br8;
            cat_lbranch:        flags = f_opd | f_memhi | f_br16;
            cat_jump:           flags = f_jmp;
            cat_jsr:            flags = f_psh_go | f_jmp;
            cat_rts:            flags = f_pul_go;
            cat_rti:            flags = f_pul_go | f_up_cc;
            cat_psh:            flags = f_opd | f_psh_go;
            cat_pul:            flags = f_opd | f_pul_go;
            cat_mul:            flags = f_up_ld16 | f_up_cc;
            cat_nmi, cat_firq, cat_irq: begin
                flags = f_psh_go;  // stack the machine state
                kind  = k_int;
            end
            cat_idx_rinc, cat_idx_rinc2, cat_idx_rdec, cat_idx_rdec2,
            cat_idx_off8, cat_idx_off16, cat_idx_r, cat_idx_ext,
            cat_idx_acc, cat_idx_dp, cat_idx_ind: begin
                flags = f_opd;
                kind  = k_idx;
            end
            default:            kind = k_halt;  // buserror and unused rows
        endcase

        uword = seq_word(a_halt, cat_buserror);
        if (cat == cat_parse_idx) begin
            if (step == 2'd0) uword = seq_word(a_idx_jmp, cat_parse_idx);
        end else if (kind != k_halt) begin
            if (step == 2'd0) begin
                uword = ctl_word(flags);
            end else if (step == 2'd1) begin
                case (kind)
                    k_int:   uword = seq_word(a_int_en | a_ni, cat_reset);
                    k_idx:   uword = seq_word(a_idx_ret, cat_reset);
                    default: uword = seq_word(a_ni, cat_reset);
                endcase
            end
        end

        fmt_known: assert (!$isunknown(uword.c.fmt))
            else $error("microword format bit unknown at %h", addr);
    end

endmodule

`default_nettype wire

// File: source/kcpu_ucode_seq.sv
// Microcode sequencer with dispatch, interrupt priority, indexed parsing and stall control
`timescale 1ns/1ps
`default_nettype none

module kcpu_ucode_seq import kcpu_isa_pkg::*, kcpu_ucode_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                mem_busy,
    input  logic                nmi_n,
    input  logic                firq_n,
    input  logic                irq_n,
    input  logic [opcat_aw-1:0] opcat,
    input  logic [opcat_aw-1:0] nx_cat,
    input  logic [opcat_aw-1:0] idx_cat,
    input  logic [2:0]          idx_rsel,
    input  logic [1:0]          idx_asel,
    input  logic                idx_ind_rq,
    output logic [ctl_w-1:0]    ctl,
    output logic [2:0]          idx_rsel_q,
    output logic [1:0]          idx_asel_q,
    output logic [3:0]          intvec,
    output logic [uaddr_w-1:0]  upc,
    output logic                buserror
);

    uword_t              uw;
    logic [opcat_aw-1:0] nx_q;   // routine after address formation
    logic                ind_q;  // indirect pass still pending
    logic                adv;

    kcpu_ucode_rom u_rom (
        .addr  (upc),
        .uword (uw)
    );

    assign adv = cen && !mem_busy && !buserror;

    // sequence words drive no flags
    assign ctl = uw.c.fmt ? '0 : {uw.c.opd, uw.c.up_lda, uw.c.up_ldb, uw.c.up_ld16,
                                  uw.c.memhi, uw.c.we, uw.c.set_pc_branch8,
                                  uw.c.set_pc_branch16, uw.c.set_pc_jmp,
                                  uw.c.psh_go, uw.c.pul_go, uw.c.up_cc};

    always_ff @(posedge clk) begin
        if (rst) begin
            upc      <= reset_entry;
            ind_q    <= 1'b0;
            intvec   <= iv_reset;
            buserror <= 1'b0;
        end else if (adv) begin
            if (!uw.s.fmt) begin
                upc <= upc + 1'b1;
            end else if (uw.s.halt) begin
                buserror <= 1'b1;  // upc frozen from here on
            end else if (uw.s.ni) begin
                nx_q <= nx_cat;
                // no interrupt right after an entry so the handler gets one opcode
                if (!nmi_n && !uw.s.int_en) begin
                    upc    <= nmi_entry;
                    intvec <= iv_nmi;
                end else if (!firq_n && !uw.s.int_en) begin
                    upc    <= firq_entry;
                    intvec <= iv_firq;
                end else if (!irq_n && !uw.s.int_en) begin
                    upc    <= irq_entry;
                    intvec <= iv_irq;
                end else begin
                    upc    <= {opcat, {step_w{1'b0}}};
                    intvec <= iv_none;
                end
            end else if (uw.s.idx_jmp) begin
                upc        <= {idx_cat, {step_w{1'b0}}};
                idx_rsel_q <= idx_rsel;
                idx_asel_q <= idx_asel;
                ind_q      <= idx_ind_rq;
            end else if (uw.s.idx_ret) begin
                upc   <= ind_q ? {cat_idx_ind, {step_w{1'b0}}} : {nx_q, {step_w{1'b0}}};
                ind_q <= 1'b0;
            end else begin
                upc <= {uw.s.target, {step_w{1'b0}}};
            end
        end
    end

    // back-pressure holds the microprogram counter
    upc_hold: assert property (@(posedge clk) disable iff (rst) mem_busy |=> $stable(upc))
        else $error("upc moved during mem_busy");

    // a bus error is only left through reset
    buserror_sticky: assert property (@(posedge clk) disable iff (rst) buserror |=> buserror)
        else $error("buserror cleared without reset");

endmodule

`default_nettype wire

// File: tests/kcpu_ctrl_tb.sv
// Testbench for the kcpu control unit driving vectors from a data file and checking routine order
`timescale 1ns/1ps
`default_nettype none

module kcpu_ctrl_tb import kcpu_isa_pkg::*, kcpu_ucode_pkg::*; ();

    localparam int max_wait = 64;  // cycles allowed per wait
    localparam int max_vec  = 100;

    logic               clk;
    logic               rst;
    logic               cen;
    logic [7:0]         op;
    logic [7:0]         mdata;
    logic               mem_busy;
    logic               nmi_n;
    logic               firq_n;
    logic               irq_n;
    logic [ctl_w-1:0]   ctl;
    logic [2:0]         idx_rsel_q;
    logic [1:0]         idx_asel_q;
    logic [3:0]         intvec;
    logic [uaddr_w-1:0] upc;
    logic               buserror;

    logic [7:0]         vec_mem [0:1023];
    logic [uaddr_w-1:0] prev_upc;
    logic               stall_en;
    integer             seed;

    tb_clock u_clk (.clk(clk));

    kcpu_ctrl uut (
        .clk        (clk),
        .rst        (rst),
        .cen        (cen),
        .op         (op),
        .mdata      (mdata),
        .mem_busy   (mem_busy),
        .nmi_n      (nmi_n),
        .firq_n     (firq_n),
        .irq_n      (irq_n),
        .ctl        (ctl),
        .idx_rsel_q (idx_rsel_q),
        .idx_asel_q (idx_asel_q),
        .intvec     (intvec),
        .upc        (upc),
        .buserror   (buserror)
    );

    // ten bytes per vector
    function automatic logic [7:0] vec_byte(input int vi, input int k);
        logic [9:0] a;
        a = 10'(vi * 10 + k);
        return vec_mem[a];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act)
            abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    endtask

    // one clock with the stall hold checked and a new mem_busy drawn
    task automatic step_cycle(output logic moved);
        @(negedge clk);
        if (mem_busy && upc != prev_upc)
            abort_run("upc moved while mem_busy was high");
        moved    = (upc != prev_upc);
        prev_upc = upc;
        mem_busy = stall_en && ($random(seed) % 2 != 0);
    endtask

    // next routine starts when upc moves onto a step 0 address
    task automatic wait_entry(output logic [opcat_aw-1:0] cat);
        logic moved;
        logic found;
        int   n;
        found = 1'b0;
        cat   = '0;
        for (n = 0; n < max_wait && !found; n++) begin
            step_cycle(moved);
            if (moved && upc[1:0] == 2'b00) begin
                cat   = upc[uaddr_w-1:step_w];
                found = 1'b1;
            end
        end
        if (!found)
            abort_run("timed out waiting for the next microcode routine to start");
    endtask

    task automatic run_vector(input int vi);
        logic [7:0]          kind;
        logic [7:0]          lines;
        logic [7:0]          sel;
        logic [opcat_aw-1:0] cat;
        logic [uaddr_w-1:0]  hold;
        logic                moved;
        string               tag;
        int                  k;
        int                  n;
        kind  = vec_byte(vi, 0);
        lines = vec_byte(vi, 3);
        sel   = vec_byte(vi, 9);
        tag   = $sformatf("vector %0d stall %0d", vi, stall_en);
        @(negedge clk);
        rst      = 1'b1;
        mem_busy = 1'b0;
        op       = vec_byte(vi, 1);
        mdata    = vec_byte(vi, 2);
        {nmi_n, firq_n, irq_n} = lines[2:0];
        repeat (2) @(negedge clk);  // two reset cycles
        rst = 1'b0;
        check_value({tag, " reset upc"}, 16'(reset_entry), 16'(upc));
        check_value({tag, " reset ctl"}, 16'h0000, 16'(ctl));
        check_value({tag, " reset intvec"}, 16'(iv_reset), 16'(intvec));
        check_value({tag, " reset buserror"}, 16'h0000, 16'(buserror));
        prev_upc = upc;
        mem_busy = stall_en && ($random(seed) % 2 != 0);

        for (k = 4; k < 8; k++) begin
            if (vec_byte(vi, k) != 8'hff) begin
                wait_entry(cat);
                check_value($sformatf("%s routine %0d", tag, k - 4),
                            16'(vec_byte(vi, k)), 16'(cat));
                // psh_go on interrupt entry, opd on address formation
                if (cat inside {cat_nmi, cat_firq, cat_irq})
                    check_value({tag, " entry ctl"}, 16'h0004, 16'(ctl));
                else if (cat >= cat_idx_rinc)
                    check_value({tag, " entry ctl"}, 16'h0800, 16'(ctl));
                else if (cat == cat_parse_idx || cat == cat_buserror)
                    check_value({tag, " entry ctl"}, 16'h0000, 16'(ctl));
                if (k == 4)
                    check_value({tag, " intvec"}, 16'(vec_byte(vi, 8)), 16'(intvec));
            end
        end

        if (kind == 8'h01) begin
            check_value({tag, " idx_rsel_q"}, 16'(sel[6:4]), 16'(idx_rsel_q));
            check_value({tag, " idx_asel_q"}, 16'(sel[1:0]), 16'(idx_asel_q));
        end
        if (kind == 8'h03) begin
            for (n = 0; n < max_wait && !buserror; n++)
                step_cycle(moved);
            if (!buserror)
                abort_run("buserror never rose after an undefined opcode or postbyte");
            hold = {cat_buserror, {step_w{1'b0}}};  // halt word of the buserror routine
            repeat (8) begin  // frozen until the next reset
                step_cycle(moved);
                check_value({tag, " frozen upc"}, 16'(hold), 16'(upc));
                check_value({tag, " buserror held"}, 16'h0001, 16'(buserror));
            end
        end else begin
            check_value({tag, " buserror"}, 16'h0000, 16'(buserror));
        end
    endtask

    initial begin
        int p;
        int vi;
        rst      = 1'b1;
        cen      = 1'b1;
        op       = 8'h00;
        mdata    = 8'h00;
        mem_busy = 1'b0;
        nmi_n    = 1'b1;
        firq_n   = 1'b1;
        irq_n    = 1'b1;
        prev_upc = '0;
        stall_en = 1'b0;
        seed     = 32'hc471;
        $readmemh("tests/kcpu_ctrl_testdata.hex", vec_mem);
        if ($isunknown(vec_byte(0, 0)))
            abort_run("test vector file could not be read");

        // same vectors without and then with random stalls
        for (p = 0; p < 2; p++) begin
            stall_en = (p == 1);
            for (vi = 0; vi < max_vec && vec_byte(vi, 0) != 8'hff; vi++)
                run_vector(vi);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/kcpu_ctrl_testdata.hex
// kind op postbyte lines cat0 cat1 cat2 cat3 intvec sel, lines = {nmi_n, firq_n, irq_n}
// kind 00 plain, 01 indexed, 02 interrupt, 03 bus error; ff ends a routine list or the file
// plain dispatch
00 86 00 07 04 04 ff ff 00 00
00 cc 00 07 05 05 ff ff 00 00
00 4f 00 07 06 06 ff ff 00 00
00 5a 00 07 07 07 ff ff 00 00
00 81 00 07 08 08 ff ff 00 00
00 83 00 07 09 09 ff ff 00 00
00 27 00 07 0e 0e ff ff 00 00
00 16 00 07 0f 0f ff ff 00 00
00 ad 00 07 11 11 ff ff 00 00
00 3b 00 07 13 13 ff ff 00 00
00 35 00 07 15 15 ff ff 00 00
00 3d 00 07 16 16 ff ff 00 00
// indexed, sel = {rsel in bits 6..4, asel in bits 1..0}
01 a6 04 07 18 24 0a 18 00 00
01 ec 35 07 18 25 0b 18 00 31
01 a1 5e 07 18 26 2a 08 00 52
01 a7 a8 07 18 28 2a 0c 00 20
01 ed 1b 07 18 23 2a 0d 00 13
01 e7 c4 07 18 29 0c 18 00 40
01 a6 61 07 18 21 0a 18 00 61
// interrupt priority
02 12 00 03 01 17 01 ff 04 00
02 12 00 00 01 17 01 ff 04 00
02 12 00 05 02 17 02 ff 02 00
02 12 00 04 02 17 02 ff 02 00
02 12 00 06 03 17 03 ff 01 00
// bus error
03 01 00 07 19 ff ff ff 00 00
03 a6 96 07 18 19 ff ff 00 00
03 a6 8a 07 18 19 ff ff 00 00
ff ff ff ff ff ff ff ff ff ff

// File: tests/tb_clock.sv
// Testbench clock source for the kcpu control unit with a 10 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #5 clk = ~clk;  // half period

endmodule

`default_nettype wire
